// File: hdl/topn_consts.svh
`ifndef TOPN_CONSTS_SVH
`define TOPN_CONSTS_SVH

// Sample key and tag widths
`define TOPN_KEY_W 16
`define TOPN_TAG_W 8

// Tree levels, the design keeps the top (2**depth - 1) keys
`define TOPN_TREE_DEPTH 3
`define TOPN_NUM_NODES ((1 << `TOPN_TREE_DEPTH) - 1)

// Worst-case cycles for an entry to sift from root to leaf
`define TOPN_SETTLE (2 * `TOPN_TREE_DEPTH)

`endif

// File: hdl/topn_pkg.sv
`default_nettype none

`include "topn_consts.svh"

package topn_pkg;

  // Class sits above the key in the rank, so empty sorts lowest and spent highest
  typedef enum logic [1:0] {
    CLS_EMPTY = 2'd0,
    CLS_LIVE  = 2'd1,
    CLS_SPENT = 2'd2
  } entry_class_t;

  // One heap slot, rank is {cls, key} compared unsigned
  typedef struct packed {
    entry_class_t            cls;
    logic [`TOPN_KEY_W-1:0]  key;
    logic [`TOPN_TAG_W-1:0]  tag;
  } heap_entry_t;

endpackage

`default_nettype wire

// File: hdl/heap_node_sort.sv
`timescale 1ns/1ps
`default_nettype none

`include "topn_consts.svh"

module heap_node_sort (
  input  wire topn_pkg::heap_entry_t parent,
  input  wire topn_pkg::heap_entry_t left_child,
  input  wire topn_pkg::heap_entry_t right_child,
  output topn_pkg::heap_entry_t      new_parent,
  output topn_pkg::heap_entry_t      new_left_child,
  output topn_pkg::heap_entry_t      new_right_child
);

  localparam int RANK_W = 2 + `TOPN_KEY_W;

  logic [RANK_W-1:0] parent_rank;
  logic [RANK_W-1:0] left_rank;
  logic [RANK_W-1:0] right_rank;
  logic              take_left;
  logic              take_right;

  always_comb begin
    parent_rank = {parent.cls, parent.key};
    left_rank   = {left_child.cls, left_child.key};
    right_rank  = {right_child.cls, right_child.key};

    // Strictly smaller child wins, left wins a tie between children
    take_left  = (left_rank < parent_rank) && (left_rank <= right_rank);
    take_right = (right_rank < parent_rank) && !take_left;

    new_parent      = parent;
    new_left_child  = left_child;
    new_right_child = right_child;
    if (take_left) begin
      new_parent     = left_child;
      new_left_child = parent;
    end else if (take_right) begin
      new_parent      = right_child;
      new_right_child = parent;
    end
  end

endmodule

`default_nettype wire

// File: hdl/register_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "topn_consts.svh"

module register_tree (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        tree_clear,
  input  wire                        replace,
  input  wire topn_pkg::heap_entry_t new_entry,
  output topn_pkg::heap_entry_t      root
);

  localparam int NUM_NODES = `TOPN_NUM_NODES;
  localparam int NUM_INNER = NUM_NODES / 2;

  localparam topn_pkg::heap_entry_t EMPTY_ENTRY = '{
    cls: topn_pkg::CLS_EMPTY,
    key: '0,
    tag: '0
  };

  // Heap storage, node n has children 2n+1 and 2n+2
  topn_pkg::heap_entry_t tree [NUM_NODES];

  // Sort results of every inner node
  topn_pkg::heap_entry_t sort_parent [NUM_INNER];
  topn_pkg::heap_entry_t sort_left   [NUM_INNER];
  topn_pkg::heap_entry_t sort_right  [NUM_INNER];

  // Level parity of each inner node
  logic [NUM_INNER-1:0] node_odd;

  // Low on even-level cycles, high on odd-level cycles
  logic level_odd;

  generate
    for (genvar i = 0; i < NUM_INNER; i++) begin : g_node
      localparam int LEVEL = $clog2(i + 2) - 1;

      assign node_odd[i] = (LEVEL % 2) == 1;

      heap_node_sort u_sort (
        .parent          (tree[i]),
        .left_child      (tree[2*i+1]),
        .right_child     (tree[2*i+2]),
        .new_parent      (sort_parent[i]),
        .new_left_child  (sort_left[i]),
        .new_right_child (sort_right[i])
      );
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (rst || tree_clear) begin
      level_odd <= 1'b0;
      for (int n = 0; n < NUM_NODES; n++) begin
        tree[n] <= EMPTY_ENTRY;
      end
    end else begin
      level_odd <= !level_odd;

      // Adjacent levels never share a cycle, so no slot gets two writers
      for (int n = 0; n < NUM_INNER; n++) begin
        if (node_odd[n] == level_odd) begin
          tree[n]     <= sort_parent[n];
          tree[2*n+1] <= sort_left[n];
          tree[2*n+2] <= sort_right[n];
        end
      end

      // New entry takes the root slot over any sort result
      if (replace) begin
        tree[0] <= new_entry;
      end
    end
  end

  assign root = tree[0];

endmodule

`default_nettype wire

// File: hdl/topn_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "topn_consts.svh"

module topn_sequencer (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        clear,
  input  wire                        sample_valid,
  input  wire                        drain,
  input  wire topn_pkg::heap_entry_t sample,
  input  wire topn_pkg::heap_entry_t root,
  output logic                       replace,
  output topn_pkg::heap_entry_t      new_entry,
  output logic                       tree_clear,
  output logic                       busy,
  output logic                       result_valid,
  output logic                       drain_done,
  output topn_pkg::heap_entry_t      result
);

  localparam int NUM_NODES = `TOPN_NUM_NODES;
  localparam int SETTLE    = `TOPN_SETTLE;
  localparam int RANK_W    = 2 + `TOPN_KEY_W;
  localparam int CNT_W     = $clog2(SETTLE + 1);
  localparam int ROUND_W   = $clog2(NUM_NODES);

  localparam topn_pkg::heap_entry_t SPENT_ENTRY = '{
    cls: topn_pkg::CLS_SPENT,
    key: '0,
    tag: '0
  };

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETTLE,
    ST_DRAIN
  } state_t;

  state_t               state;
  logic [CNT_W-1:0]     settle_cnt;
  logic [ROUND_W-1:0]   round_cnt;
  logic                 draining;

  topn_pkg::heap_entry_t sample_live;
  logic [RANK_W-1:0]     sample_rank;
  logic [RANK_W-1:0]     root_rank;
  logic                  sample_wins;
  logic                  start_drain;
  logic                  take_sample;

  assign tree_clear = clear;

  always_comb begin
    // Incoming class is ignored and every sample counts as live
    sample_live     = sample;
    sample_live.cls = topn_pkg::CLS_LIVE;

    sample_rank = {topn_pkg::CLS_LIVE, sample.key};
    root_rank   = {root.cls, root.key};
    sample_wins = sample_rank > root_rank;

    // Drain has priority over a sample arriving in the same cycle
    start_drain = (state == ST_IDLE) && !busy && !clear && drain;
    take_sample = (state == ST_IDLE) && !busy && !clear && !drain &&
                  sample_valid && sample_wins;
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      state        <= ST_IDLE;
      busy         <= 1'b0;
      replace      <= 1'b0;
      result_valid <= 1'b0;
      drain_done   <= 1'b0;
      draining     <= 1'b0;
      settle_cnt   <= '0;
      round_cnt    <= '0;
    end else begin
      replace      <= 1'b0;
      result_valid <= 1'b0;
      drain_done   <= 1'b0;

      case (state)
        ST_IDLE: begin
          busy <= 1'b0;
          if (start_drain) begin
            busy      <= 1'b1;
            draining  <= 1'b1;
            round_cnt <= '0;
            state     <= ST_DRAIN;
          end else if (take_sample) begin
            busy       <= 1'b1;
            replace    <= 1'b1;
            settle_cnt <= CNT_W'(SETTLE);
            state      <= ST_SETTLE;
          end
        end

        ST_SETTLE: begin
          if (settle_cnt != '0) begin
            settle_cnt <= settle_cnt - 1'b1;
          end else if (!draining) begin
            busy  <= 1'b0;
            state <= ST_IDLE;
          end else if (round_cnt == ROUND_W'(NUM_NODES - 1)) begin
            // Busy stays up through the done pulse and drops in idle
            drain_done <= 1'b1;
            draining   <= 1'b0;
            state      <= ST_IDLE;
          end else begin
            round_cnt <= round_cnt + 1'b1;
            state     <= ST_DRAIN;
          end
        end

        ST_DRAIN: begin
          // Empty roots are pushed out silently
          result_valid <= (root.cls == topn_pkg::CLS_LIVE);
          replace      <= 1'b1;
          settle_cnt   <= CNT_W'(SETTLE);
          state        <= ST_SETTLE;
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_sample) begin
      new_entry <= sample_live;
    end else if (state == ST_DRAIN) begin
      new_entry <= SPENT_ENTRY;
    end

    if (state == ST_DRAIN) begin
      result <= root;
    end
  end

endmodule

`default_nettype wire

// File: hdl/topn_top.sv
`timescale 1ns/1ps
`default_nettype none

module topn_top (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        clear,
  input  wire                        sample_valid,
  input  wire topn_pkg::heap_entry_t sample,
  input  wire                        drain,
  output logic                       busy,
  output logic                       result_valid,
  output topn_pkg::heap_entry_t      result,
  output logic                       drain_done
);

  // Sequencer to tree
  logic                  replace;
  logic                  tree_clear;
  topn_pkg::heap_entry_t new_entry;

  // Tree back to sequencer
  topn_pkg::heap_entry_t root;

  topn_sequencer u_sequencer (
    .clk          (clk),
    .rst          (rst),
    .clear        (clear),
    .sample_valid (sample_valid),
    .drain        (drain),
    .sample       (sample),
    .root         (root),
    .replace      (replace),
    .new_entry    (new_entry),
    .tree_clear   (tree_clear),
    .busy         (busy),
    .result_valid (result_valid),
    .drain_done   (drain_done),
    .result       (result)
  );

  register_tree u_tree (
    .clk        (clk),
    .rst        (rst),
    .tree_clear (tree_clear),
    .replace    (replace),
    .new_entry  (new_entry),
    .root       (root)
  );

endmodule

`default_nettype wire

// File: dv/topn_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "topn_consts.svh"

module topn_tb;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_NODES  = `TOPN_NUM_NODES;
  localparam int SETTLE     = `TOPN_SETTLE;
  localparam int NUM_PHASES = 6;
  localparam int WAIT_LIMIT = 2 * NUM_NODES * (SETTLE + 2) + 16;

  // One row per phase of the run
  typedef struct packed {
    int count;
    int fixed_base;
    bit use_lcg;
    bit do_clear;
    bit do_drain;
    int exp_results;
  } phase_t;

  phase_t phases [NUM_PHASES] = '{
    '{0,  0, 1'b0, 1'b0, 1'b1, 0},  // Drain straight out of reset
    '{4,  0, 1'b0, 1'b1, 1'b1, 4},
    '{30, 0, 1'b1, 1'b1, 1'b1, 7},
    '{13, 4, 1'b0, 1'b1, 1'b1, 7},  // Seven large keys, then small keys that lose
    '{5,  0, 1'b1, 1'b1, 1'b0, 0},
    '{6,  0, 1'b1, 1'b1, 1'b1, 6}   // Only this stream may come out
  };

  logic [`TOPN_KEY_W-1:0] fixed_keys [17] = '{
    16'h0300, 16'h0100, 16'h0400, 16'h0200,
    16'hf700, 16'hf100, 16'hf500, 16'hf300, 16'hf600, 16'hf200, 16'hf400,
    16'h0500, 16'he000, 16'h0050, 16'h8000, 16'h0001, 16'hf0ff
  };
  logic [`TOPN_TAG_W-1:0] fixed_tags [17] = '{
    8'h11, 8'h12, 8'h13, 8'h14,
    8'h21, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26, 8'h27,
    8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36
  };

  logic                  clk;
  logic                  rst;
  logic                  clear;
  logic                  sample_valid;
  logic                  drain;
  topn_pkg::heap_entry_t sample;
  logic                  busy;
  logic                  result_valid;
  logic                  drain_done;
  topn_pkg::heap_entry_t result;

  // Reference model state
  topn_pkg::heap_entry_t model_q [$];
  topn_pkg::heap_entry_t expect_q [$];
  topn_pkg::heap_entry_t got_q [$];
  bit                    used_key [1 << `TOPN_KEY_W];
  logic [31:0]           lcg_state;
  int                    errors;
  int                    checks;

  topn_top uut (
    .clk          (clk),
    .rst          (rst),
    .clear        (clear),
    .sample_valid (sample_valid),
    .sample       (sample),
    .drain        (drain),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result),
    .drain_done   (drain_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // A key enters the top N when fewer than N kept keys are larger
  function automatic logic predict_accept(input logic [`TOPN_KEY_W-1:0] key);
    int larger;
    larger = 0;
    foreach (model_q[i]) begin
      if (model_q[i].key > key) begin
        larger++;
      end
    end
    return larger < NUM_NODES;
  endfunction

  function automatic int watchdog_cycles();
    int cycles;
    cycles = 20;
    foreach (phases[p]) begin
      cycles += phases[p].count * (SETTLE + 6) + 10;
      if (phases[p].do_drain) begin
        cycles += NUM_NODES * (SETTLE + 2) + 10;
      end
    end
    return 4 * cycles;
  endfunction

  task automatic next_lcg_sample(output topn_pkg::heap_entry_t s);
    logic [`TOPN_KEY_W-1:0] key;
    do begin
      lcg_state = lcg_next(lcg_state);
      key = lcg_state[15 +: `TOPN_KEY_W];
    end while (used_key[key]);
    used_key[key] = 1'b1;
    // Class on the way in should be ignored
    s.cls = topn_pkg::CLS_SPENT;
    s.key = key;
    s.tag = lcg_state[7 +: `TOPN_TAG_W];
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while (busy && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (busy) begin
      $display("ERROR at %0t: busy stayed high for %0d cycles", $time, WAIT_LIMIT);
      errors++;
    end
  endtask

  task automatic send_sample(input topn_pkg::heap_entry_t s);
    topn_pkg::heap_entry_t live;
    logic                  exp_accept;
    live = s;
    live.cls = topn_pkg::CLS_LIVE;
    exp_accept = predict_accept(s.key);
    wait_idle();
    @(posedge clk);
    sample_valid <= 1'b1;
    sample <= s;
    @(posedge clk);
    sample_valid <= 1'b0;
    // Busy rises only for a sample that replaces the root
    @(negedge clk);
    checks++;
    if (busy !== exp_accept) begin
      $display("MISMATCH at %0t: key %h gave busy %b, expected %b",
               $time, s.key, busy, exp_accept);
      errors++;
    end
    model_q.push_back(live);
  endtask

  task automatic run_drain(input int exp_results);
    topn_pkg::heap_entry_t sorted [$];
    topn_pkg::heap_entry_t tmp;
    int                    keep;
    int                    waited;
    logic                  done;
    sorted = model_q;
    for (int i = 1; i < sorted.size(); i++) begin
      for (int j = i; j > 0 && sorted[j-1].key > sorted[j].key; j--) begin
        tmp = sorted[j];
        sorted[j] = sorted[j-1];
        sorted[j-1] = tmp;
      end
    end
    // Largest N keys, ascending
    keep = (sorted.size() < NUM_NODES) ? sorted.size() : NUM_NODES;
    expect_q.delete();
    for (int i = sorted.size() - keep; i < sorted.size(); i++) begin
      expect_q.push_back(sorted[i]);
    end
    got_q.delete();
    wait_idle();
    @(posedge clk);
    drain <= 1'b1;
    @(posedge clk);
    drain <= 1'b0;
    done = 1'b0;
    waited = 0;
    while (!done && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
      if (result_valid) begin
        got_q.push_back(result);
      end
      if (drain_done) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("ERROR at %0t: drain_done never arrived within %0d cycles", $time, WAIT_LIMIT);
      errors++;
    end
    checks++;
    if (got_q.size() != expect_q.size() || got_q.size() != exp_results) begin
      $display("MISMATCH at %0t: %0d results, model expects %0d, table expects %0d",
               $time, got_q.size(), expect_q.size(), exp_results);
      errors++;
    end
    foreach (got_q[i]) begin
      checks++;
      if (i < expect_q.size() && got_q[i] !== expect_q[i]) begin
        $display("MISMATCH at %0t: result %0d cls %0d key %h tag %h, expected key %h tag %h",
                 $time, i, got_q[i].cls, got_q[i].key, got_q[i].tag,
                 expect_q[i].key, expect_q[i].tag);
        errors++;
      end
    end
  endtask

  task automatic run_phase(input int idx, input phase_t ph);
    topn_pkg::heap_entry_t s;
    $display("Phase %0d: %0d samples", idx, ph.count);
    if (ph.do_clear) begin
      wait_idle();
      @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      model_q.delete();
    end
    for (int n = 0; n < ph.count; n++) begin
      if (ph.use_lcg) begin
        next_lcg_sample(s);
      end else begin
        s.cls = topn_pkg::CLS_EMPTY;
        s.key = fixed_keys[ph.fixed_base + n];
        s.tag = fixed_tags[ph.fixed_base + n];
      end
      send_sample(s);
    end
    if (ph.do_drain) begin
      run_drain(ph.exp_results);
    end
  endtask

  initial begin
    errors = 0;
    checks = 0;
    lcg_state = 32'd53411;
    rst = 1'b1;
    clear = 1'b0;
    sample_valid = 1'b0;
    drain = 1'b0;
    sample = '0;
    foreach (fixed_keys[k]) begin
      used_key[fixed_keys[k]] = 1'b1;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checks++;
    if (busy !== 1'b0 || result_valid !== 1'b0 || drain_done !== 1'b0) begin
      $display("MISMATCH at %0t: after reset busy %b result_valid %b drain_done %b",
               $time, busy, result_valid, drain_done);
      errors++;
    end
    for (int p = 0; p < NUM_PHASES; p++) begin
      run_phase(p, phases[p]);
    end
    $display("Closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    int limit;
    limit = watchdog_cycles();
    #(limit * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles, the run did not finish", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/topn_pkg.sv
hdl/heap_node_sort.sv
hdl/register_tree.sv
hdl/topn_sequencer.sv
hdl/topn_top.sv
dv/topn_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the topn testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module topn_tb -f project.f -Mdir obj_dir -o topn_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/topn_sim > sim.log 2>&1
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
